// ==== filelist.f ====
+incdir+design
design/cdd_pkg.sv
design/cdd_status_mailbox.sv
design/cdd_bit_shifter.sv
design/cdd_byte_sequencer.sv
design/cdd_command_frame.sv
design/cdd_link.sv
verif/cdd_link_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the drive link testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module cdd_link_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vcdd_link_tb 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qF 'All tests passed!'; then
	exit 0
fi
echo "Simulation did not report a pass"
exit 1

// ==== verif/cdd_link_tb.sv ====
`include "cdd_config.svh"

module cdd_link_tb;

	import cdd_pkg::*;

	logic        clk_sys = 1'b0;
	logic        reset;
	cdd_frame_u  status_frame;
	logic        status_toggle;
	logic        comclk;
	logic        hdata;
	logic        cdata;
	logic        comreq_n;
	logic        comsync_n;
	cdd_frame_u  cmd_frame;
	logic        cmd_toggle;

	cdd_frame_u  expected_q[$];
	cdd_byte_t   model_count_a;
	cdd_byte_t   model_count_b;
	int          flip_count;
	int          frames_sent;
	logic        seen_toggle;

	cdd_link dut (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.status_frame  (status_frame),
		.status_toggle (status_toggle),
		.comclk        (comclk),
		.hdata         (hdata),
		.cdata         (cdata),
		.comreq_n      (comreq_n),
		.comsync_n     (comsync_n),
		.cmd_frame     (cmd_frame),
		.cmd_toggle    (cmd_toggle)
	);

	always #50 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////
	// Compare and failure tasks
	////////////////////////////////////////////////////////////

	task automatic check_byte(input string name, input cdd_byte_t got, input cdd_byte_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	task automatic check_frame(input string name, input cdd_frame_u got, input cdd_frame_u exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t while waiting for %s", $time, what);
		$display("Test failures found");
		$fatal(1);
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Host bytes with bytes 9 and 8 taken from the command counts
	function automatic cdd_frame_u expected_frame(input cdd_frame_u host, input cdd_byte_t cnt_a,
			input cdd_byte_t cnt_b);
		cdd_frame_u exp;
		exp          = host;
		exp.bytes[9] = cnt_a;
		exp.bytes[8] = cnt_b;
		return exp;
	endfunction

	function automatic cdd_frame_u random_frame();
		cdd_frame_u f;
		for (int i = 0; i < `CDD_FRAME_BYTES; i++) begin
			f.bytes[i] = cdd_byte_t'($urandom);
		end
		return f;
	endfunction

	// Compares each delivered frame against the oldest expected one
	always @(negedge clk_sys) begin
		if (reset) begin
			seen_toggle = cmd_toggle;
		end else if (cmd_toggle !== seen_toggle) begin
			seen_toggle = cmd_toggle;
			flip_count  = flip_count + 1;
			if (expected_q.size() == 0) begin
				$display("cmd_toggle flipped at %0t with no command frame outstanding", $time);
				$display("Test failures found");
				$fatal(1);
			end else begin
				check_frame("cmd_frame", cmd_frame, expected_q.pop_front());
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Host link model
	////////////////////////////////////////////////////////////

	task automatic apply_reset();
		reset         = 1'b1;
		status_toggle = 1'b0;
		comclk        = 1'b1;
		repeat (4) @(negedge clk_sys);
		reset         = 1'b0;
		model_count_a = '0;
		model_count_b = '0;
	endtask

	task automatic post_status(output cdd_frame_u posted);
		posted        = random_frame();
		status_frame  = posted;
		status_toggle = ~status_toggle;
	endtask

	// One byte as eight comclk pulses with a varying hold time
	task automatic exchange_byte(input cdd_byte_t send, input logic sync_level,
			output cdd_byte_t got);
		int waited;
		waited = 0;
		while (comreq_n !== 1'b0) begin
			@(negedge clk_sys);
			waited++;
			if (waited > 3000) begin
				report_timeout("comreq_n to fall");
			end
		end
		for (int b = 0; b < 8; b++) begin
			comclk = 1'b0;
			hdata  = send[b];
			repeat (4 + $urandom_range(2)) @(negedge clk_sys);
			check_level("comsync_n", comsync_n, sync_level);
			got[b] = cdata;
			comclk = 1'b1;
			repeat (4 + $urandom_range(2)) @(negedge clk_sys);
		end
	endtask

	task automatic exchange_bytes(input cdd_frame_u status, input cdd_frame_u host,
			input int count);
		cdd_byte_t got;
		for (int i = 0; i < count; i++) begin
			exchange_byte(host.bytes[i], (i != 0), got);
			check_byte($sformatf("status byte %0d", i), got, status.bytes[i]);
		end
	endtask

	task automatic run_frame(input cdd_byte_t command);
		cdd_frame_u host;
		cdd_frame_u posted;
		int         waited;
		host          = random_frame();
		host.bytes[0] = command;
		expected_q.push_back(expected_frame(host, model_count_a, model_count_b));
		if (command == `CDD_CMD_COUNT_A) begin
			model_count_a = model_count_a + 8'd1;
		end
		if (command == `CDD_CMD_COUNT_B) begin
			model_count_b = model_count_b + 8'd1;
		end
		frames_sent++;
		post_status(posted);
		exchange_bytes(posted, host, `CDD_FRAME_BYTES);
		waited = 0;
		while (flip_count != frames_sent) begin
			@(negedge clk_sys);
			waited++;
			if (waited > 200) begin
				report_timeout("cmd_toggle to flip");
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		cdd_frame_u posted;
		cdd_frame_u partial;
		void'($urandom(62430));
		reset         = 1'b1;
		status_frame  = '0;
		status_toggle = 1'b0;
		comclk        = 1'b1;
		hdata         = 1'b0;
		flip_count    = 0;
		frames_sent   = 0;
		apply_reset();
		@(negedge clk_sys);
		check_level("comreq_n", comreq_n, 1'b1);
		check_level("comsync_n", comsync_n, 1'b1);
		check_level("cmd_toggle", cmd_toggle, 1'b0);
		check_frame("cmd_frame", cmd_frame, '0);

		run_frame(`CDD_CMD_COUNT_A);
		run_frame(`CDD_CMD_COUNT_B);
		run_frame(`CDD_CMD_COUNT_A);
		run_frame(cdd_byte_t'($urandom));

		// Repost during the gap after byte 3
		partial = random_frame();
		post_status(posted);
		exchange_bytes(posted, partial, 4);
		run_frame(`CDD_CMD_COUNT_B);

		// Counters start over after a reset
		apply_reset();
		run_frame(`CDD_CMD_COUNT_A);
		check_byte("cmd_frame byte 9", cmd_frame.bytes[9], 8'h00);
		check_byte("cmd_frame byte 8", cmd_frame.bytes[8], 8'h00);
		run_frame(`CDD_CMD_COUNT_B);

		if (expected_q.size() == 0 && flip_count == frames_sent) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("%0d command frames were never delivered", expected_q.size());
			$display("Test failures found");
			$fatal(1);
		end
	end

endmodule

// ==== design/cdd_link.sv ====
module cdd_link (
	input  logic               clk_sys,
	input  logic               reset,
	input  cdd_pkg::cdd_frame_u status_frame,
	input  logic               status_toggle,
	input  logic               comclk,
	input  logic               hdata,
	output logic               cdata,
	output logic               comreq_n,
	output logic               comsync_n,
	output cdd_pkg::cdd_frame_u cmd_frame,
	output logic               cmd_toggle
);

	import cdd_pkg::*;

	cdd_frame_u status_latched;
	cdd_frame_u host_frame;
	cdd_byte_t  tx_byte;
	cdd_byte_t  rx_byte;
	logic       trans_start;
	logic       trans_next;
	logic       byte_load;
	logic       byte_done;
	logic       frame_done;

	////////////////////////////////////////////////////////////
	// Drive status path
	////////////////////////////////////////////////////////////

	cdd_status_mailbox u_mailbox (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.status_frame   (status_frame),
		.status_toggle  (status_toggle),
		.status_latched (status_latched),
		.trans_start    (trans_start)
	);

	cdd_byte_sequencer u_sequencer (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.status_latched (status_latched),
		.trans_start    (trans_start),
		.rx_byte        (rx_byte),
		.byte_done      (byte_done),
		.tx_byte        (tx_byte),
		.byte_load      (byte_load),
		.trans_next     (trans_next),
		.comsync_n      (comsync_n),
		.host_frame     (host_frame),
		.frame_done     (frame_done)
	);

	// Serial pins toward the CD block
	cdd_bit_shifter u_shifter (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.comclk     (comclk),
		.hdata      (hdata),
		.tx_byte    (tx_byte),
		.byte_load  (byte_load),
		.trans_next (trans_next),
		.cdata      (cdata),
		.comreq_n   (comreq_n),
		.rx_byte    (rx_byte),
		.byte_done  (byte_done)
	);

	cdd_command_frame u_command (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.host_frame (host_frame),
		.frame_done (frame_done),
		.cmd_frame  (cmd_frame),
		.cmd_toggle (cmd_toggle)
	);

endmodule

// ==== design/cdd_command_frame.sv ====
`include "cdd_config.svh"

module cdd_command_frame (
	input  logic               clk_sys,
	input  logic               reset,
	input  cdd_pkg::cdd_frame_u host_frame,
	input  logic               frame_done,
	output cdd_pkg::cdd_frame_u cmd_frame,
	output logic               cmd_toggle
);

	import cdd_pkg::*;

	cdd_byte_t  count_a;
	cdd_byte_t  count_b;
	cdd_frame_u delivered;

	// Bytes 9 and 8 carry the counts seen before this frame
	always_comb begin
		delivered                = host_frame;
		delivered.fields.count_a = count_a;
		delivered.fields.count_b = count_b;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			count_a    <= '0;
			count_b    <= '0;
			cmd_frame  <= '0;
			cmd_toggle <= 1'b0;
		end else if (frame_done) begin
			cmd_frame  <= delivered;
			cmd_toggle <= ~cmd_toggle;
			// Counters wrap at 256
			if (host_frame.fields.command == `CDD_CMD_COUNT_A) begin
				count_a <= count_a + 8'd1;
			end
			if (host_frame.fields.command == `CDD_CMD_COUNT_B) begin
				count_b <= count_b + 8'd1;
			end
		end
	end

	a_toggle_after_done : assert property (@(posedge clk_sys) disable iff (reset)
		(cmd_toggle != $past(cmd_toggle)) |-> $past(frame_done));

endmodule

// ==== design/cdd_byte_sequencer.sv ====
`include "cdd_config.svh"

module cdd_byte_sequencer (
	input  logic               clk_sys,
	input  logic               reset,
	input  cdd_pkg::cdd_frame_u status_latched,
	input  logic               trans_start,
	input  cdd_pkg::cdd_byte_t  rx_byte,
	input  logic               byte_done,
	output cdd_pkg::cdd_byte_t  tx_byte,
	output logic               byte_load,
	output logic               trans_next,
	output logic               comsync_n,
	output cdd_pkg::cdd_frame_u host_frame,
	output logic               frame_done
);

	import cdd_pkg::*;

	localparam int GAP_W = $clog2(`CDD_BYTE_GAP + 1);
	localparam cdd_byte_index_t LAST_BYTE = 4'(`CDD_FRAME_BYTES - 1);

	cdd_byte_index_t byte_idx;
	logic [GAP_W-1:0] gap_cnt;

	////////////////////////////////////////////////////////////
	// Payload, outgoing byte select and incoming byte store
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (trans_start) begin
			tx_byte <= status_latched.bytes[0];
		end else if (byte_done) begin
			host_frame.bytes[byte_idx] <= rx_byte;
			if (byte_idx < LAST_BYTE) begin
				tx_byte <= status_latched.bytes[byte_idx + 4'd1];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Byte walk, frame sync and gap timer
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			byte_idx   <= '0;
			gap_cnt    <= '0;
			byte_load  <= 1'b0;
			trans_next <= 1'b0;
			comsync_n  <= 1'b1;
			frame_done <= 1'b0;
		end else begin
			byte_load  <= 1'b0;
			trans_next <= 1'b0;
			frame_done <= 1'b0;
			if (trans_start) begin
				// Also taken mid frame so a new frame restarts at byte 0
				byte_idx  <= '0;
				byte_load <= 1'b1;
				comsync_n <= 1'b0;
				gap_cnt   <= GAP_W'(`CDD_BYTE_GAP);
			end else if (byte_done) begin
				comsync_n <= 1'b1;
				if (byte_idx < LAST_BYTE) begin
					byte_idx  <= byte_idx + 4'd1;
					byte_load <= 1'b1;
					gap_cnt   <= GAP_W'(`CDD_BYTE_GAP);
				end else begin
					// No further request after the last byte
					byte_idx   <= '0;
					frame_done <= 1'b1;
				end
			end else if (gap_cnt != '0) begin
				gap_cnt    <= gap_cnt - GAP_W'(1);
				trans_next <= (gap_cnt == GAP_W'(1));
			end
		end
	end

	a_index_range : assert property (@(posedge clk_sys) disable iff (reset)
		byte_idx < `CDD_FRAME_BYTES);

endmodule

// ==== design/cdd_bit_shifter.sv ====
module cdd_bit_shifter (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              comclk,
	input  logic              hdata,
	input  cdd_pkg::cdd_byte_t tx_byte,
	input  logic              byte_load,
	input  logic              trans_next,
	output logic              cdata,
	output logic              comreq_n,
	output cdd_pkg::cdd_byte_t rx_byte,
	output logic              byte_done
);

	import cdd_pkg::*;

	logic           comclk_q;
	logic           comclk_fall;
	logic           comclk_rise;
	cdd_byte_t      tx_shift;
	cdd_bit_index_t bit_cnt;

	assign comclk_fall = !comclk && comclk_q;
	assign comclk_rise = comclk && !comclk_q;

	////////////////////////////////////////////////////////////
	// Data path
	////////////////////////////////////////////////////////////

	// Host bits enter at the top, so bit 0 ends up at the bottom
	always_ff @(posedge clk_sys) begin
		if (byte_load) begin
			tx_shift <= tx_byte;
		end else if (comclk_fall) begin
			tx_shift <= {1'b0, tx_shift[7:1]};
		end
		if (!byte_load && comclk_rise) begin
			rx_byte <= {hdata, rx_byte[7:1]};
		end
	end

	////////////////////////////////////////////////////////////
	// Edge detect, bit count and request line
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			comclk_q  <= 1'b1;
			cdata     <= 1'b0;
			comreq_n  <= 1'b1;
			bit_cnt   <= '0;
			byte_done <= 1'b0;
		end else begin
			comclk_q  <= comclk;
			byte_done <= 1'b0;
			if (byte_load) begin
				bit_cnt <= '0;
			end else if (comclk_fall) begin
				// LSB first
				cdata <= tx_shift[0];
			end else if (comclk_rise) begin
				bit_cnt   <= bit_cnt + 3'd1;
				byte_done <= (bit_cnt == 3'd7);
			end
			if (trans_next) begin
				comreq_n <= 1'b0;
			end else if (byte_load || comclk_rise) begin
				comreq_n <= 1'b1;
			end
		end
	end

	a_load_done_apart : assert property (@(posedge clk_sys) disable iff (reset)
		!(byte_load && byte_done));

endmodule

// ==== design/cdd_status_mailbox.sv ====
`include "cdd_config.svh"

module cdd_status_mailbox (
	input  logic               clk_sys,
	input  logic               reset,
	input  cdd_pkg::cdd_frame_u status_frame,
	input  logic               status_toggle,
	output cdd_pkg::cdd_frame_u status_latched,
	output logic               trans_start
);

	localparam int DELAY_W = $clog2(`CDD_START_DELAY + 1);

	logic               toggle_last;
	logic [DELAY_W-1:0] delay_cnt;

	// Frame is captured together with the toggle edge
	always_ff @(posedge clk_sys) begin
		if (status_toggle != toggle_last) begin
			status_latched <= status_frame;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			toggle_last <= 1'b0;
			delay_cnt   <= '0;
			trans_start <= 1'b0;
		end else begin
			trans_start <= 1'b0;
			if (status_toggle != toggle_last) begin
				toggle_last <= status_toggle;
				// A repost restarts the wait from the top
				delay_cnt   <= DELAY_W'(`CDD_START_DELAY);
			end else if (delay_cnt != '0) begin
				delay_cnt   <= delay_cnt - DELAY_W'(1);
				trans_start <= (delay_cnt == DELAY_W'(1));
			end
		end
	end

	a_start_single : assert property (@(posedge clk_sys) disable iff (reset)
		trans_start |=> !trans_start);

endmodule

// ==== design/cdd_pkg.sv ====
`include "cdd_config.svh"

package cdd_pkg;

	typedef logic [7:0] cdd_byte_t;

	// Byte position in a frame, 0 to 11
	typedef logic [3:0] cdd_byte_index_t;

	// Bit position within a byte
	typedef logic [2:0] cdd_bit_index_t;

	// Decoded view, most significant field first
	typedef struct packed {
		logic [15:0] trailer;
		cdd_byte_t   count_a;
		cdd_byte_t   count_b;
		logic [55:0] params;
		cdd_byte_t   command;
	} cdd_frame_fields_t;

	// Same 96 bits as bytes for the serial side with byte 0 at the bottom
	typedef union packed {
		cdd_byte_t [`CDD_FRAME_BYTES-1:0] bytes;
		cdd_frame_fields_t                fields;
	} cdd_frame_u;

endpackage

// ==== design/cdd_config.svh ====
`ifndef CDD_CONFIG_SVH
`define CDD_CONFIG_SVH

// Frame geometry of the drive link
`define CDD_FRAME_BYTES 12

// Cycles from a status toggle to the first byte load
`define CDD_START_DELAY 15

// Idle cycles between the end of one byte and the next request
`define CDD_BYTE_GAP 1023

// Host commands whose occurrences are counted
// Count of code A goes to byte 9, code B to byte 8
`define CDD_CMD_COUNT_A 8'h06
`define CDD_CMD_COUNT_B 8'h09

`endif
